//--- vec_macros.svh
// Size, opcode and function code constants for the vector coprocessor
`ifndef VEC_MACROS_SVH
`define VEC_MACROS_SVH

// Vector geometry
`define VEC_VLEN      128
`define VEC_ELEN      32
`define VEC_NR_LANES  2
`define VEC_VLMAX     (`VEC_VLEN / `VEC_ELEN)
`define VEC_ROWS      (`VEC_VLMAX / `VEC_NR_LANES)
`define VEC_NR_VREGS  32

// OP-V major opcode
`define VEC_OPC_V     7'b1010111

// funct3 categories
`define VEC_F3_IVV    3'b000
`define VEC_F3_MVV    3'b010
`define VEC_F3_IVX    3'b100
`define VEC_F3_CFG    3'b111

// funct6 codes
`define VEC_F6_ADD    6'b000000
`define VEC_F6_SUB    6'b000010
`define VEC_F6_AND    6'b001001
`define VEC_F6_OR     6'b001010
`define VEC_F6_XOR    6'b001011
`define VEC_F6_EXT    6'b001100
`define VEC_F6_MV     6'b010111

`endif

//--- vec_pkg.sv
// Shared types for the vector coprocessor, from host instruction to lane command
`include "vec_macros.svh"

package vec_pkg;

  typedef logic [`VEC_ELEN-1:0] elem_t;

  // 0 .. VLMAX inclusive
  typedef logic [$clog2(`VEC_VLMAX+1)-1:0] vl_t;

  typedef logic [4:0] vreg_idx_t;

  //////////////////////////////////////////////////
  // Instruction views
  //////////////////////////////////////////////////

  // OP-V arithmetic layout
  typedef struct packed {
    logic [5:0] funct6;
    logic       vm;
    vreg_idx_t  vs2;
    vreg_idx_t  vs1;  // Also rs1 for .vx forms
    logic [2:0] funct3;
    vreg_idx_t  vd;
    logic [6:0] opcode;
  } insn_arith_t;

  // vsetvli layout
  typedef struct packed {
    logic        cfg;
    logic [10:0] zimm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } insn_cfg_t;

  typedef union packed {
    insn_arith_t arith;
    insn_cfg_t   cfg;
  } insn_u;

  //////////////////////////////////////////////////
  // Host side
  //////////////////////////////////////////////////

  typedef struct packed {
    insn_u insn;
    elem_t rs1_data;
  } acc_req_t;

  typedef struct packed {
    elem_t data;
    logic  error;
  } acc_resp_t;

  //////////////////////////////////////////////////
  // Backend
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_MV,
    OP_EXT
  } vec_op_e;

  typedef struct packed {
    vec_op_e   op;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    vreg_idx_t vd;
    elem_t     scalar;
    logic      use_scalar;
    vl_t       vl;
  } vec_req_t;

  typedef struct packed {
    vec_op_e                         op;
    vreg_idx_t                       vs1;
    vreg_idx_t                       vs2;
    vreg_idx_t                       vd;
    elem_t                           scalar;
    logic                            use_scalar;
    logic [$clog2(`VEC_ROWS)-1:0]    row;
    vl_t                             vl;
  } lane_cmd_t;

endpackage

//--- vec_dispatcher.sv
// Dispatcher that decodes host instructions, owns vl and returns responses in order
`timescale 1ns/1ps
`include "vec_macros.svh"

module vec_dispatcher (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  vec_pkg::acc_req_t   acc_req_i,
  input  logic                acc_req_valid_i,
  output logic                acc_req_ready_o,
  output vec_pkg::acc_resp_t  acc_resp_o,
  output logic                acc_resp_valid_o,
  output vec_pkg::vec_req_t   vec_req_o,
  output logic                vec_req_valid_o,
  input  logic                vec_req_ready_i,
  input  logic                vec_resp_valid_i,
  input  vec_pkg::elem_t      vec_resp_data_i,
  input  logic                seq_idle_i
);

  // vsew = e32 and vlmul = m1 in the low vtype bits
  localparam logic [5:0] VTYPE_E32M1 = 6'b010000;

  vec_pkg::acc_req_t    req_q;
  logic                 req_valid_q, req_valid_d;
  logic                 ready_q;
  vec_pkg::vl_t         vl_q, new_vl;
  vec_pkg::insn_arith_t insn_ar;
  vec_pkg::insn_cfg_t   insn_cf;
  vec_pkg::vec_op_e     dec_op;
  logic                 dec_scalar, is_vec, is_cfg;
  logic                 acc_fire, vec_fire, scalar_fire;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  assign insn_ar = req_q.insn.arith;
  assign insn_cf = req_q.insn.cfg;

  assign is_cfg = (insn_cf.opcode == `VEC_OPC_V) && (insn_cf.funct3 == `VEC_F3_CFG) &&
                  !insn_cf.cfg && (insn_cf.zimm[5:0] == VTYPE_E32M1);

  always_comb begin
    dec_op     = vec_pkg::OP_ADD;
    dec_scalar = 1'b0;
    is_vec     = 1'b0;
    // Masked forms are not supported
    if ((insn_ar.opcode == `VEC_OPC_V) && insn_ar.vm) begin
      case (insn_ar.funct3)
        `VEC_F3_IVV: begin
          is_vec = 1'b1;
          case (insn_ar.funct6)
            `VEC_F6_ADD: dec_op = vec_pkg::OP_ADD;
            `VEC_F6_SUB: dec_op = vec_pkg::OP_SUB;
            `VEC_F6_AND: dec_op = vec_pkg::OP_AND;
            `VEC_F6_OR:  dec_op = vec_pkg::OP_OR;
            `VEC_F6_XOR: dec_op = vec_pkg::OP_XOR;
            default:     is_vec = 1'b0;
          endcase
        end
        `VEC_F3_IVX: begin
          dec_scalar = 1'b1;
          if (insn_ar.funct6 == `VEC_F6_ADD) begin
            is_vec = 1'b1;
            dec_op = vec_pkg::OP_ADD;
          end else if (insn_ar.funct6 == `VEC_F6_MV && insn_ar.vs2 == '0) begin
            is_vec = 1'b1;
            dec_op = vec_pkg::OP_MV;
          end
        end
        `VEC_F3_MVV: begin
          // Index comes from the scalar operand
          if (insn_ar.funct6 == `VEC_F6_EXT) begin
            is_vec     = 1'b1;
            dec_scalar = 1'b1;
            dec_op     = vec_pkg::OP_EXT;
          end
        end
        default: is_vec = 1'b0;
      endcase
    end
  end

  // Clamp requested length to VLMAX
  assign new_vl = (req_q.rs1_data >= `VEC_VLMAX) ? vec_pkg::vl_t'(`VEC_VLMAX)
                                                 : vec_pkg::vl_t'(req_q.rs1_data);

  //////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////

  assign acc_req_ready_o = ready_q;
  assign acc_fire        = acc_req_valid_i && ready_q;
  assign vec_req_valid_o = req_valid_q && is_vec;
  assign vec_fire        = vec_req_valid_o && vec_req_ready_i;
  // Config and illegal wait until all vector work has answered
  assign scalar_fire     = req_valid_q && !is_vec && seq_idle_i && !vec_resp_valid_i;
  assign req_valid_d     = acc_fire || (req_valid_q && !(vec_fire || scalar_fire));

  always_comb begin
    vec_req_o            = '0;
    vec_req_o.op         = dec_op;
    vec_req_o.vs1        = insn_ar.vs1;
    vec_req_o.vs2        = insn_ar.vs2;
    vec_req_o.vd         = insn_ar.vd;
    vec_req_o.scalar     = req_q.rs1_data;
    vec_req_o.use_scalar = dec_scalar;
    vec_req_o.vl         = vl_q;
  end

  assign acc_resp_valid_o = scalar_fire || vec_resp_valid_i;

  always_comb begin
    acc_resp_o = '0;
    if (vec_resp_valid_i) begin
      acc_resp_o.data = vec_resp_data_i;
    end else if (is_cfg) begin
      acc_resp_o.data = vec_pkg::elem_t'(new_vl);
    end else begin
      acc_resp_o.error = req_valid_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_q       <= '0;
      req_valid_q <= 1'b0;
      ready_q     <= 1'b0;
      vl_q        <= vec_pkg::vl_t'(`VEC_VLMAX);
    end else begin
      req_valid_q <= req_valid_d;
      ready_q     <= !req_valid_d;
      if (acc_fire) begin
        req_q <= acc_req_i;
      end
      if (scalar_fire && is_cfg) begin
        vl_q <= new_vl;
      end
    end
  end

  // Held request must not change under back-pressure
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    vec_req_valid_o && !vec_req_ready_i |=> vec_req_valid_o && $stable(vec_req_o));

endmodule

//--- vec_sequencer.sv
// Sequencer that steps one vector request over the lane rows and signals completion
`timescale 1ns/1ps
`include "vec_macros.svh"

module vec_sequencer (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  vec_pkg::vec_req_t                     vec_req_i,
  input  logic                                  vec_req_valid_i,
  output logic                                  vec_req_ready_o,
  output logic                                  vec_resp_valid_o,
  output vec_pkg::elem_t                        vec_resp_data_o,
  output logic                                  seq_idle_o,
  output vec_pkg::lane_cmd_t                    lane_cmd_o,
  output logic                                  lane_cmd_valid_o,
  input  vec_pkg::elem_t [`VEC_NR_LANES-1:0]    lane_rdata_i
);

  localparam int unsigned ROW_W  = $clog2(`VEC_ROWS);
  localparam int unsigned LANE_W = $clog2(`VEC_NR_LANES);

  vec_pkg::vec_req_t  req_q;
  logic               busy_q;
  logic [ROW_W-1:0]   row_q;
  logic               resp_valid_q;
  vec_pkg::elem_t     resp_data_q;

  logic               is_ext, ext_in_range, last_cmd;
  logic [LANE_W-1:0]  ext_lane;
  logic [ROW_W-1:0]   ext_row, cmd_row;

  //////////////////////////////////////////////////
  // Element index split for vext.x.v
  //////////////////////////////////////////////////

  assign is_ext       = (req_q.op == vec_pkg::OP_EXT);
  assign ext_lane     = req_q.scalar[LANE_W-1:0];
  assign ext_row      = req_q.scalar[LANE_W +: ROW_W];
  assign ext_in_range = (req_q.scalar < `VEC_VLMAX);

  assign cmd_row  = is_ext ? ext_row : row_q;
  // Extract touches a single row
  assign last_cmd = is_ext || (row_q == ROW_W'(`VEC_ROWS - 1));

  always_comb begin
    lane_cmd_o            = '0;
    lane_cmd_o.op         = req_q.op;
    lane_cmd_o.vs1        = req_q.vs1;
    lane_cmd_o.vs2        = req_q.vs2;
    lane_cmd_o.vd         = req_q.vd;
    lane_cmd_o.scalar     = req_q.scalar;
    lane_cmd_o.use_scalar = req_q.use_scalar;
    lane_cmd_o.row        = cmd_row;
    lane_cmd_o.vl         = req_q.vl;
  end

  assign lane_cmd_valid_o = busy_q;
  assign vec_req_ready_o  = !busy_q;
  assign seq_idle_o       = !busy_q;
  assign vec_resp_valid_o = resp_valid_q;
  assign vec_resp_data_o  = resp_data_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_q        <= '0;
      busy_q       <= 1'b0;
      row_q        <= '0;
      resp_valid_q <= 1'b0;
      resp_data_q  <= '0;
    end else begin
      resp_valid_q <= 1'b0;
      if (vec_req_valid_i && !busy_q) begin
        req_q  <= vec_req_i;
        busy_q <= 1'b1;
        row_q  <= '0;
      end else if (busy_q) begin
        if (last_cmd) begin
          busy_q       <= 1'b0;
          resp_valid_q <= 1'b1;
          // Only vext returns data and an out of range index gives zero
          resp_data_q  <= (is_ext && ext_in_range) ? lane_rdata_i[ext_lane] : '0;
        end else begin
          row_q <= row_q + 1'b1;
        end
      end
    end
  end

  a_row_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lane_cmd_valid_o |-> (lane_cmd_o.row < `VEC_ROWS));

endmodule

//--- vec_lane.sv
// Vector lane with its register file slice and a 32-bit integer ALU
`timescale 1ns/1ps
`include "vec_macros.svh"

module vec_lane #(
  parameter int unsigned LANE_ID = 0
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  vec_pkg::lane_cmd_t  lane_cmd_i,
  input  logic                lane_cmd_valid_i,
  output vec_pkg::elem_t      lane_rdata_o
);

  // Indexed by register, then row
  vec_pkg::elem_t vrf_q [`VEC_NR_VREGS][`VEC_ROWS];

  vec_pkg::elem_t vs1_data, vs2_data, vd_data, opb, alu_res;
  vec_pkg::vl_t   elem_idx;
  logic           wr_en;

  assign vs1_data = vrf_q[lane_cmd_i.vs1][lane_cmd_i.row];
  assign vs2_data = vrf_q[lane_cmd_i.vs2][lane_cmd_i.row];
  assign vd_data  = vrf_q[lane_cmd_i.vd][lane_cmd_i.row];

  assign opb = lane_cmd_i.use_scalar ? lane_cmd_i.scalar : vs1_data;

  //////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////

  always_comb begin
    case (lane_cmd_i.op)
      vec_pkg::OP_ADD: alu_res = vs2_data + opb;
      vec_pkg::OP_SUB: alu_res = vs2_data - opb;
      vec_pkg::OP_AND: alu_res = vs2_data & opb;
      vec_pkg::OP_OR:  alu_res = vs2_data | opb;
      vec_pkg::OP_XOR: alu_res = vs2_data ^ opb;
      vec_pkg::OP_MV:  alu_res = opb;
      default:         alu_res = vs2_data;
    endcase
  end

  // Global element number held at this row
  assign elem_idx = vec_pkg::vl_t'(lane_cmd_i.row) * vec_pkg::vl_t'(`VEC_NR_LANES) +
                    vec_pkg::vl_t'(LANE_ID);

  // Tail elements are left undisturbed
  assign wr_en = lane_cmd_valid_i && (lane_cmd_i.op != vec_pkg::OP_EXT) &&
                 (elem_idx < lane_cmd_i.vl);

  // vext reads vs2 through this port
  assign lane_rdata_o = vs2_data;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < `VEC_NR_VREGS; r++) begin
        for (int w = 0; w < `VEC_ROWS; w++) begin
          vrf_q[r][w] <= '0;
        end
      end
    end else if (wr_en) begin
      vrf_q[lane_cmd_i.vd][lane_cmd_i.row] <= alu_res;
    end
  end

  // An element past vl still holds its old value after the command
  a_tail_kept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lane_cmd_valid_i && (elem_idx >= lane_cmd_i.vl)
    |=> vrf_q[$past(lane_cmd_i.vd)][$past(lane_cmd_i.row)] == $past(vd_data));

endmodule

//--- ara_lite.sv
// Top level of the vector coprocessor joining dispatcher, sequencer and lanes
`timescale 1ns/1ps
`include "vec_macros.svh"

module ara_lite (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  vec_pkg::acc_req_t   acc_req_i,
  input  logic                acc_req_valid_i,
  output logic                acc_req_ready_o,
  output vec_pkg::acc_resp_t  acc_resp_o,
  output logic                acc_resp_valid_o
);

  // Dispatcher to sequencer
  vec_pkg::vec_req_t                  vec_req;
  logic                               vec_req_valid;
  logic                               vec_req_ready;
  logic                               vec_resp_valid;
  vec_pkg::elem_t                     vec_resp_data;
  logic                               seq_idle;

  // Sequencer to lanes
  vec_pkg::lane_cmd_t                 lane_cmd;
  logic                               lane_cmd_valid;
  vec_pkg::elem_t [`VEC_NR_LANES-1:0] lane_rdata;

  vec_dispatcher i_dispatcher (
    .clk_i            (clk_i           ),
    .rst_n_i          (rst_n_i         ),
    .acc_req_i        (acc_req_i       ),
    .acc_req_valid_i  (acc_req_valid_i ),
    .acc_req_ready_o  (acc_req_ready_o ),
    .acc_resp_o       (acc_resp_o      ),
    .acc_resp_valid_o (acc_resp_valid_o),
    .vec_req_o        (vec_req         ),
    .vec_req_valid_o  (vec_req_valid   ),
    .vec_req_ready_i  (vec_req_ready   ),
    .vec_resp_valid_i (vec_resp_valid  ),
    .vec_resp_data_i  (vec_resp_data   ),
    .seq_idle_i       (seq_idle        )
  );

  vec_sequencer i_sequencer (
    .clk_i            (clk_i           ),
    .rst_n_i          (rst_n_i         ),
    .vec_req_i        (vec_req         ),
    .vec_req_valid_i  (vec_req_valid   ),
    .vec_req_ready_o  (vec_req_ready   ),
    .vec_resp_valid_o (vec_resp_valid  ),
    .vec_resp_data_o  (vec_resp_data   ),
    .seq_idle_o       (seq_idle        ),
    .lane_cmd_o       (lane_cmd        ),
    .lane_cmd_valid_o (lane_cmd_valid  ),
    .lane_rdata_i     (lane_rdata      )
  );

  for (genvar l = 0; l < `VEC_NR_LANES; l++) begin : gen_lanes
    vec_lane #(
      .LANE_ID (l)
    ) i_lane (
      .clk_i            (clk_i           ),
      .rst_n_i          (rst_n_i         ),
      .lane_cmd_i       (lane_cmd        ),
      .lane_cmd_valid_i (lane_cmd_valid  ),
      .lane_rdata_o     (lane_rdata[l]   )
    );
  end

endmodule

//--- tb_tasks.svh
// Directed stimulus tasks and instruction encoders for the vector coprocessor testbench
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

function automatic vec_pkg::insn_u enc_arith(input logic [5:0] f6, input logic [2:0] f3,
                                             input int vs2, input int vs1, input int vd);
  vec_pkg::insn_u insn;
  insn.arith.funct6 = f6;
  insn.arith.vm     = 1'b1;
  insn.arith.vs2    = 5'(vs2);
  insn.arith.vs1    = 5'(vs1);
  insn.arith.funct3 = f3;
  insn.arith.vd     = 5'(vd);
  insn.arith.opcode = `VEC_OPC_V;
  return insn;
endfunction

// e32, m1 in zimm
function automatic vec_pkg::insn_u enc_vsetvli();
  vec_pkg::insn_u insn;
  insn.cfg.cfg    = 1'b0;
  insn.cfg.zimm   = 11'h010;
  insn.cfg.rs1    = 5'd1;
  insn.cfg.funct3 = `VEC_F3_CFG;
  insn.cfg.rd     = 5'd1;
  insn.cfg.opcode = `VEC_OPC_V;
  return insn;
endfunction

// a is the vs2 element, b is vs1 or the scalar
function automatic vec_pkg::elem_t expect_op(input logic [5:0] f6, input vec_pkg::elem_t a,
                                             input vec_pkg::elem_t b);
  case (f6)
    `VEC_F6_ADD: return a + b;
    `VEC_F6_SUB: return a - b;
    `VEC_F6_AND: return a & b;
    `VEC_F6_OR:  return a | b;
    `VEC_F6_XOR: return a ^ b;
    default:     return b;
  endcase
endfunction

// Data only matters on a good response
task automatic check_resp(input vec_pkg::acc_resp_t resp, input vec_pkg::elem_t exp_data,
                          input logic exp_err, input string what);
  check_eq(32'(resp.error), 32'(exp_err), {what, " error flag"});
  if (!exp_err) check_eq(resp.data, exp_data, {what, " data"});
endtask

task automatic issue(input vec_pkg::insn_u insn, input vec_pkg::elem_t rs1_data,
                     input vec_pkg::elem_t exp_data, input logic exp_err, input string what);
  vec_pkg::acc_req_t  req;
  vec_pkg::acc_resp_t resp;
  req.insn     = insn;
  req.rs1_data = rs1_data;
  send_req(req);
  acc_req_valid = 1'b0;
  wait_resp(resp);
  check_resp(resp, exp_data, exp_err, what);
  @(posedge clk);
  #1;
endtask

task automatic set_vl(input int unsigned avl);
  int unsigned new_vl;
  new_vl = (avl < `VEC_VLMAX) ? avl : `VEC_VLMAX;
  issue(enc_vsetvli(), avl, new_vl, 1'b0, "vsetvli");
  shadow_vl = new_vl;
endtask

task automatic splat(input int vd, input vec_pkg::elem_t val);
  issue(enc_arith(`VEC_F6_MV, `VEC_F3_IVX, 0, 0, vd), val, '0, 1'b0, "vmv.v.x");
  for (int i = 0; i < shadow_vl; i++) shadow[vd][i] = val;
endtask

task automatic arith_vv(input logic [5:0] f6, input int vd, input int vs2, input int vs1);
  issue(enc_arith(f6, `VEC_F3_IVV, vs2, vs1, vd), '0, '0, 1'b0, "vector-vector op");
  for (int i = 0; i < shadow_vl; i++) begin
    shadow[vd][i] = expect_op(f6, shadow[vs2][i], shadow[vs1][i]);
  end
endtask

task automatic arith_vx(input int vd, input int vs2, input vec_pkg::elem_t scalar);
  issue(enc_arith(`VEC_F6_ADD, `VEC_F3_IVX, vs2, 0, vd), scalar, '0, 1'b0, "vadd.vx");
  for (int i = 0; i < shadow_vl; i++) begin
    shadow[vd][i] = expect_op(`VEC_F6_ADD, shadow[vs2][i], scalar);
  end
endtask

task automatic read_elem(input int vs2, input int unsigned idx);
  vec_pkg::elem_t expected;
  expected = (idx < `VEC_VLMAX) ? shadow[vs2][idx] : '0;
  issue(enc_arith(`VEC_F6_EXT, `VEC_F3_MVV, vs2, 0, 0), idx, expected, 1'b0, "vext.x.v");
endtask

task automatic queue_req(input vec_pkg::insn_u insn, input vec_pkg::elem_t rs1_data,
                         input vec_pkg::elem_t exp_data, input logic exp_err);
  vec_pkg::acc_req_t req;
  req.insn     = insn;
  req.rs1_data = rs1_data;
  burst_req.push_back(req);
  burst_data.push_back(exp_data);
  burst_err.push_back(exp_err);
endtask

// Valid stays high across requests while responses are collected in parallel
task automatic test_back_to_back();
  vec_pkg::elem_t     s;
  vec_pkg::acc_resp_t resp;
  s = rand_word();
  queue_req(enc_vsetvli(), 3, 3, 1'b0);
  shadow_vl = 3;
  queue_req(enc_arith(`VEC_F6_MV, `VEC_F3_IVX, 0, 0, 20), s, '0, 1'b0);
  for (int i = 0; i < 3; i++) shadow[20][i] = s;
  queue_req(enc_arith(`VEC_F6_ADD, `VEC_F3_IVV, 20, 8, 21), '0, '0, 1'b0);
  for (int i = 0; i < 3; i++) shadow[21][i] = shadow[20][i] + shadow[8][i];
  queue_req(enc_arith(`VEC_F6_EXT, `VEC_F3_MVV, 21, 0, 0), 1, shadow[21][1], 1'b0);
  queue_req(enc_arith(`VEC_F6_EXT, `VEC_F3_MVV, 21, 0, 0), 3, shadow[21][3], 1'b0);
  queue_req(enc_vsetvli(), 9, `VEC_VLMAX, 1'b0);
  shadow_vl = `VEC_VLMAX;
  queue_req(enc_arith(6'b111111, `VEC_F3_IVV, 8, 9, 21), '0, '0, 1'b1);
  s = rand_word();
  queue_req(enc_arith(`VEC_F6_ADD, `VEC_F3_IVX, 21, 0, 21), s, '0, 1'b0);
  for (int i = 0; i < `VEC_VLMAX; i++) shadow[21][i] = shadow[21][i] + s;
  queue_req(enc_arith(`VEC_F6_EXT, `VEC_F3_MVV, 21, 0, 0), 3, shadow[21][3], 1'b0);
  queue_req(enc_arith(`VEC_F6_EXT, `VEC_F3_MVV, 8, 0, 0), 7, '0, 1'b0);
  fork
    begin
      for (int k = 0; k < burst_req.size(); k++) send_req(burst_req[k]);
      acc_req_valid = 1'b0;
    end
    begin
      for (int k = 0; k < burst_req.size(); k++) begin
        wait_resp(resp);
        check_resp(resp, burst_data[k], burst_err[k], "back-to-back response");
      end
    end
  join
  repeat (10) begin
    @(negedge clk);
    check_eq(32'(acc_resp_valid), 32'd0, "extra response valid");
  end
  @(posedge clk);
  #1;
endtask

`endif

//--- tb_ara_lite.sv
// Testbench top for the vector coprocessor with clock, reset, DUT, stimulus and checks
`timescale 1ns/1ps
`include "vec_macros.svh"

module tb_ara_lite;

  localparam int TIMEOUT_CYC = 100;

  logic               clk = 1'b0;
  logic               rst_n;
  vec_pkg::acc_req_t  acc_req;
  logic               acc_req_valid;
  logic               acc_req_ready;
  vec_pkg::acc_resp_t acc_resp;
  logic               acc_resp_valid;

  // Predicted register contents, indexed by register then element
  vec_pkg::elem_t     shadow [`VEC_NR_VREGS][`VEC_VLMAX];
  int unsigned        shadow_vl;
  logic [31:0]        lfsr_q;

  // Pending back-to-back requests and their expected responses
  vec_pkg::acc_req_t  burst_req [$];
  vec_pkg::elem_t     burst_data [$];
  logic               burst_err [$];

  ara_lite DUT (
    .clk_i            (clk           ),
    .rst_n_i          (rst_n         ),
    .acc_req_i        (acc_req       ),
    .acc_req_valid_i  (acc_req_valid ),
    .acc_req_ready_o  (acc_req_ready ),
    .acc_resp_o       (acc_resp      ),
    .acc_resp_valid_o (acc_resp_valid)
  );

  always #2 clk = ~clk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand_word();
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int b = 0; b < 32; b++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns: %s is %08h, expected %08h", $time, what, actual, expected);
      $display("SIMULATION FAILED");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timed out while waiting for %s", what);
    $display("SIMULATION FAILED");
    $fatal(1, "Stopped on timeout");
  endtask

  // Present a request and hold it until the DUT takes it
  task automatic send_req(input vec_pkg::acc_req_t req);
    int n;
    n             = 0;
    acc_req       = req;
    acc_req_valid = 1'b1;
    @(negedge clk);
    while (!acc_req_ready) begin
      n++;
      if (n > TIMEOUT_CYC) abort_on_timeout("request ready");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic wait_resp(output vec_pkg::acc_resp_t resp);
    int n;
    n = 0;
    @(negedge clk);
    while (!acc_resp_valid) begin
      n++;
      if (n > TIMEOUT_CYC) abort_on_timeout("a response");
      @(negedge clk);
    end
    resp = acc_resp;
  endtask

  `include "tb_tasks.svh"

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic read_all(input int vreg);
    for (int i = 0; i < `VEC_VLMAX; i++) begin
      read_elem(vreg, i);
    end
  endtask

  // Distinct random value per element by shrinking vl between splats
  task automatic fill_random(input int vreg);
    for (int k = `VEC_VLMAX; k >= 1; k--) begin
      set_vl(k);
      splat(vreg, rand_word());
    end
  endtask

  task automatic test_vsetvl();
    set_vl(0);
    splat(1, rand_word());
    read_all(1);
    set_vl(3);
    splat(1, rand_word());
    read_all(1);
    set_vl(9);
  endtask

  task automatic test_splat();
    for (int r = 2; r < 6; r++) begin
      splat(r, rand_word());
      for (int i = 0; i < `VEC_VLMAX + 2; i++) begin
        read_elem(r, i);
      end
    end
  endtask

  task automatic test_arith();
    logic [5:0] ops [5];
    ops = '{`VEC_F6_ADD, `VEC_F6_SUB, `VEC_F6_AND, `VEC_F6_OR, `VEC_F6_XOR};
    fill_random(8);
    fill_random(9);
    set_vl(`VEC_VLMAX);
    for (int k = 0; k < 5; k++) begin
      arith_vv(ops[k], 10 + k, 8, 9);
      read_all(10 + k);
    end
    arith_vx(15, 8, rand_word());
    read_all(15);
  endtask

  // Elements 2 and 3 of v12 keep their random contents
  task automatic test_tail();
    fill_random(12);
    set_vl(2);
    arith_vv(`VEC_F6_ADD, 12, 8, 9);
    read_all(12);
    set_vl(`VEC_VLMAX);
  endtask

  task automatic test_illegal();
    vec_pkg::insn_u insn;
    issue(enc_arith(6'b111111, `VEC_F3_IVV, 8, 9, 10), '0, '0, 1'b1, "bad funct6");
    insn          = enc_arith(`VEC_F6_ADD, `VEC_F3_IVV, 8, 9, 11);
    insn.arith.vm = 1'b0;
    issue(insn, '0, '0, 1'b1, "masked vadd");
    for (int r = 0; r < `VEC_NR_VREGS; r++) begin
      read_all(r);
    end
  endtask

  initial begin
    rst_n         = 1'b0;
    acc_req       = '0;
    acc_req_valid = 1'b0;
    lfsr_q        = 32'h8d7e;
    shadow_vl     = `VEC_VLMAX;
    for (int r = 0; r < `VEC_NR_VREGS; r++) begin
      for (int i = 0; i < `VEC_VLMAX; i++) begin
        shadow[r][i] = '0;
      end
    end
    repeat (5) @(posedge clk);
    #1;
    // Host side stays quiet while in reset
    check_eq(32'(acc_req_ready), 32'd0, "ready in reset");
    check_eq(32'(acc_resp_valid), 32'd0, "response valid in reset");
    rst_n = 1'b1;

    test_vsetvl();
    test_splat();
    test_arith();
    test_tail();
    test_illegal();
    test_back_to_back();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- flist.f
+incdir+.
vec_pkg.sv
vec_dispatcher.sv
vec_sequencer.sv
vec_lane.sv
ara_lite.sv
tb_ara_lite.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the vector coprocessor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ara_lite -f flist.f

out=$(./obj_dir/Vtb_ara_lite 2>&1) || true
echo "$out"

if grep -qx "SIMULATION PASSED" <<< "$out"; then
  exit 0
fi
exit 1
